// File: Makefile
TOP = tb_ninjin_gobou

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
	  --top-module $(TOP) -f src.f -o $(TOP)

run: compile
	@out="$$(./obj_dir/$(TOP) 2>&1)"; echo "$$out"; \
	  echo "$$out" | grep -qF '>>> PASS'

clean:
	rm -rf obj_dir

// File: gobou_mem.sv
`timescale 1ns/1ps
`default_nettype none

module gobou_mem #(
  parameter int DATA_WIDTH = 32,
  parameter int MEM_AWIDTH = 10
) (
  input  logic                    clk,
  input  logic                    we,
  input  logic [DATA_WIDTH/8-1:0] strb,
  input  logic [MEM_AWIDTH-1:0]   addr,
  input  logic [DATA_WIDTH-1:0]   wdata,
  output logic [DATA_WIDTH-1:0]   rdata
);

  localparam int NBYTES = DATA_WIDTH / 8;
  localparam int DEPTH  = 2 ** MEM_AWIDTH;

  logic [DATA_WIDTH-1:0] mem [DEPTH];

  // byte lanes
  always_ff @(posedge clk) begin
    if (we) begin
      for (int i = 0; i < NBYTES; i++) begin
        if (strb[i]) begin
          mem[addr][i*8 +: 8] <= wdata[i*8 +: 8];
        end
      end
    end
  end

  // registered read returns old data on a same-cycle write
  always_ff @(posedge clk) begin
    rdata <= mem[addr];
  end

endmodule

`default_nettype wire

// File: ninjin_burst_addr.sv
`timescale 1ns/1ps
`default_nettype none

module ninjin_burst_addr #(
  parameter int DATA_WIDTH = 32,
  parameter int ADDR_WIDTH = 12
) (
  input  logic                  clk,
  input  logic                  xrst,
  input  logic                  load,
  input  logic [ADDR_WIDTH-1:0] start_addr,
  input  ninjin_pkg::axi_len_t  len,
  input  ninjin_pkg::burst_e    burst,
  input  logic                  step,
  output logic [ADDR_WIDTH-1:0] addr,
  output logic                  last
);

  import ninjin_pkg::*;

  localparam int LSB = byte_lsb(DATA_WIDTH);
  localparam int WA  = ADDR_WIDTH - LSB;

  typedef logic [WA-1:0] word_t;

  axi_len_t              len_q;
  axi_len_t              cnt_q;
  burst_e                burst_q;
  logic                  done_q;
  word_t                 cur_word;
  word_t                 inc_word;
  word_t                 wrap_mask;
  word_t                 wrap_word;
  logic [ADDR_WIDTH-1:0] next_addr;

  assign cur_word  = addr[ADDR_WIDTH-1:LSB];
  assign inc_word  = cur_word + word_t'(1);
  // wrap lengths are powers of two, so len is the block mask
  assign wrap_mask = word_t'(len_q);
  assign wrap_word = (cur_word & ~wrap_mask) | (inc_word & wrap_mask);

  always_comb begin
    case (burst_q)
      BURST_FIXED: next_addr = addr;
      BURST_WRAP:  next_addr = ADDR_WIDTH'(wrap_word) << LSB;
      // reserved encoding steps like INCR
      default:     next_addr = ADDR_WIDTH'(inc_word) << LSB;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      addr    <= '0;
      len_q   <= '0;
      cnt_q   <= '0;
      burst_q <= BURST_INCR;
      done_q  <= 1'b0;
    end else if (load) begin
      addr    <= start_addr;
      len_q   <= len;
      cnt_q   <= '0;
      burst_q <= burst;
      done_q  <= 1'b0;
    end else if (step) begin
      addr   <= next_addr;
      cnt_q  <= cnt_q + axi_len_t'(1);
      done_q <= last;
    end
  end

  assign last = (cnt_q == len_q);

  a_wrap_len: assert property (@(posedge clk) disable iff (!xrst)
    (load && burst == BURST_WRAP) |-> (len inside {8'd1, 8'd3, 8'd7, 8'd15}));

  // no beat past the end of a burst until the next address
  a_step_after_last: assert property (@(posedge clk) disable iff (!xrst)
    !(step && done_q && !load));

endmodule

`default_nettype wire

// File: ninjin_gobou_top.sv
`timescale 1ns/1ps
`default_nettype none

module ninjin_gobou_top #(
  parameter int DATA_WIDTH = 32,
  parameter int ADDR_WIDTH = 12,
  parameter int ID_WIDTH   = 12,
  parameter int MEM_AWIDTH = ADDR_WIDTH - ninjin_pkg::byte_lsb(DATA_WIDTH)
) (
  input  logic                      clk,
  input  logic                      xrst,
  input  logic [ID_WIDTH-1:0]       awid,
  input  logic [ADDR_WIDTH-1:0]     awaddr,
  input  ninjin_pkg::axi_len_t      awlen,
  input  ninjin_pkg::axi_size_t     awsize,
  input  logic [1:0]                awburst,
  input  logic                      awlock,
  input  logic [3:0]                awcache,
  input  logic [2:0]                awprot,
  input  logic [3:0]                awqos,
  input  logic [3:0]                awregion,
  input  logic                      awvalid,
  output logic                      awready,
  input  logic [DATA_WIDTH-1:0]     wdata,
  input  logic [DATA_WIDTH/8-1:0]   wstrb,
  input  logic                      wlast,
  input  logic                      wvalid,
  output logic                      wready,
  output logic                      bvalid,
  output logic [ID_WIDTH-1:0]       bid,
  output ninjin_pkg::axi_resp_t     bresp,
  input  logic                      bready,
  input  logic [ID_WIDTH-1:0]       arid,
  input  logic [ADDR_WIDTH-1:0]     araddr,
  input  ninjin_pkg::axi_len_t      arlen,
  input  ninjin_pkg::axi_size_t     arsize,
  input  logic [1:0]                arburst,
  input  logic                      arlock,
  input  logic [3:0]                arcache,
  input  logic [2:0]                arprot,
  input  logic [3:0]                arqos,
  input  logic [3:0]                arregion,
  input  logic                      arvalid,
  output logic                      arready,
  output logic                      rvalid,
  output logic [ID_WIDTH-1:0]       rid,
  output logic [DATA_WIDTH-1:0]     rdata,
  output ninjin_pkg::axi_resp_t     rresp,
  output logic                      rlast,
  input  logic                      rready
);

  // memory port between slave and memory
  logic                    mem_we;
  logic [DATA_WIDTH/8-1:0] mem_strb;
  logic [MEM_AWIDTH-1:0]   mem_addr;
  logic [DATA_WIDTH-1:0]   mem_wdata;
  logic [DATA_WIDTH-1:0]   mem_rdata;

  // bus ports share names with the top
  ninjin_s_axi_gobou #(
    .DATA_WIDTH (DATA_WIDTH),
    .ADDR_WIDTH (ADDR_WIDTH),
    .ID_WIDTH   (ID_WIDTH),
    .MEM_AWIDTH (MEM_AWIDTH)
  ) u_slave (.*);

  gobou_mem #(
    .DATA_WIDTH (DATA_WIDTH),
    .MEM_AWIDTH (MEM_AWIDTH)
  ) u_mem (
    .clk   (clk),
    .we    (mem_we),
    .strb  (mem_strb),
    .addr  (mem_addr),
    .wdata (mem_wdata),
    .rdata (mem_rdata)
  );

endmodule

`default_nettype wire

// File: ninjin_pkg.sv
`default_nettype none

package ninjin_pkg;

  // ========================================
  // bus field types
  // ========================================

  // burst length minus one
  typedef logic [7:0] axi_len_t;

  // log2 of bytes per beat
  typedef logic [2:0] axi_size_t;

  typedef logic [1:0] axi_resp_t;

  typedef enum logic [1:0] {
    BURST_FIXED = 2'b00,
    BURST_INCR  = 2'b01,
    BURST_WRAP  = 2'b10
  } burst_e;

  localparam axi_resp_t RESP_OKAY = 2'b00;

  // one transaction at a time
  typedef enum logic [1:0] {
    S_IDLE,
    S_WRITE,
    S_BRESP,
    S_READ
  } slv_state_e;

  // byte offset bits within one bus word
  function automatic int byte_lsb(input int data_width);
    return $clog2(data_width / 8);
  endfunction

  function automatic axi_size_t full_size(input int data_width);
    return axi_size_t'($clog2(data_width / 8));
  endfunction

endpackage

`default_nettype wire

// File: ninjin_s_axi_gobou.sv
`timescale 1ns/1ps
`default_nettype none

module ninjin_s_axi_gobou #(
  parameter int DATA_WIDTH = 32,
  parameter int ADDR_WIDTH = 12,
  parameter int ID_WIDTH   = 12,
  parameter int MEM_AWIDTH = 10
) (
  input  logic                      clk,
  input  logic                      xrst,
  // write address
  input  logic [ID_WIDTH-1:0]       awid,
  input  logic [ADDR_WIDTH-1:0]     awaddr,
  input  ninjin_pkg::axi_len_t      awlen,
  input  ninjin_pkg::axi_size_t     awsize,
  input  logic [1:0]                awburst,
  input  logic                      awlock,
  input  logic [3:0]                awcache,
  input  logic [2:0]                awprot,
  input  logic [3:0]                awqos,
  input  logic [3:0]                awregion,
  input  logic                      awvalid,
  output logic                      awready,
  // write data
  input  logic [DATA_WIDTH-1:0]     wdata,
  input  logic [DATA_WIDTH/8-1:0]   wstrb,
  input  logic                      wlast,
  input  logic                      wvalid,
  output logic                      wready,
  // write response
  output logic                      bvalid,
  output logic [ID_WIDTH-1:0]       bid,
  output ninjin_pkg::axi_resp_t     bresp,
  input  logic                      bready,
  // read address
  input  logic [ID_WIDTH-1:0]       arid,
  input  logic [ADDR_WIDTH-1:0]     araddr,
  input  ninjin_pkg::axi_len_t      arlen,
  input  ninjin_pkg::axi_size_t     arsize,
  input  logic [1:0]                arburst,
  input  logic                      arlock,
  input  logic [3:0]                arcache,
  input  logic [2:0]                arprot,
  input  logic [3:0]                arqos,
  input  logic [3:0]                arregion,
  input  logic                      arvalid,
  output logic                      arready,
  // read data
  output logic                      rvalid,
  output logic [ID_WIDTH-1:0]       rid,
  output logic [DATA_WIDTH-1:0]     rdata,
  output ninjin_pkg::axi_resp_t     rresp,
  output logic                      rlast,
  input  logic                      rready,
  // memory port
  output logic                      mem_we,
  output logic [DATA_WIDTH/8-1:0]   mem_strb,
  output logic [MEM_AWIDTH-1:0]     mem_addr,
  output logic [DATA_WIDTH-1:0]     mem_wdata,
  input  logic [DATA_WIDTH-1:0]     mem_rdata
);

  import ninjin_pkg::*;

  localparam int LSB = byte_lsb(DATA_WIDTH);

  slv_state_e            state;
  logic [ADDR_WIDTH-1:0] waddr;
  logic [ADDR_WIDTH-1:0] raddr;
  logic                  w_last;
  logic                  r_last;
  logic                  w_load;
  logic                  r_load;
  logic                  w_step;
  logic                  r_step;

  // ========================================
  // channel select
  // ========================================

  // write wins over read in the same idle cycle
  assign w_load = (state == S_IDLE) && awvalid;
  assign r_load = (state == S_IDLE) && !awvalid && arvalid;
  assign w_step = wready && wvalid;
  assign r_step = rvalid && rready;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      state   <= S_IDLE;
      awready <= 1'b0;
      arready <= 1'b0;
      rvalid  <= 1'b0;
    end else begin
      // address ready is a one cycle pulse after acceptance
      awready <= w_load;
      arready <= r_load;
      case (state)
        S_IDLE: begin
          if (w_load) begin
            state <= S_WRITE;
          end else if (r_load) begin
            state <= S_READ;
          end
        end
        S_WRITE: begin
          if (w_step && wlast) begin
            state <= S_BRESP;
          end
        end
        S_BRESP: begin
          if (bready) begin
            state <= S_IDLE;
          end
        end
        S_READ: begin
          // one idle cycle per beat while the memory reads the next word
          if (r_step) begin
            rvalid <= 1'b0;
            if (r_last) begin
              state <= S_IDLE;
            end
          end else begin
            rvalid <= 1'b1;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // IDs held for the whole transaction
  always_ff @(posedge clk) begin
    if (w_load) begin
      bid <= awid;
    end
    if (r_load) begin
      rid <= arid;
    end
  end

  // ========================================
  // burst address generators
  // ========================================

  ninjin_burst_addr #(
    .DATA_WIDTH (DATA_WIDTH),
    .ADDR_WIDTH (ADDR_WIDTH)
  ) u_waddr (
    .clk        (clk),
    .xrst       (xrst),
    .load       (w_load),
    .start_addr (awaddr),
    .len        (awlen),
    .burst      (burst_e'(awburst)),
    .step       (w_step),
    .addr       (waddr),
    .last       (w_last)
  );

  ninjin_burst_addr #(
    .DATA_WIDTH (DATA_WIDTH),
    .ADDR_WIDTH (ADDR_WIDTH)
  ) u_raddr (
    .clk        (clk),
    .xrst       (xrst),
    .load       (r_load),
    .start_addr (araddr),
    .len        (arlen),
    .burst      (burst_e'(arburst)),
    .step       (r_step),
    .addr       (raddr),
    .last       (r_last)
  );

  // ========================================
  // responses and memory port
  // ========================================

  assign wready = (state == S_WRITE);
  assign bvalid = (state == S_BRESP);
  assign bresp  = RESP_OKAY;
  assign rresp  = RESP_OKAY;
  assign rlast  = rvalid && r_last;
  assign rdata  = mem_rdata;

  assign mem_we    = w_step;
  assign mem_strb  = wstrb;
  assign mem_wdata = wdata;
  assign mem_addr  = (state == S_READ) ? raddr[LSB +: MEM_AWIDTH]
                                       : waddr[LSB +: MEM_AWIDTH];

  a_aw_full_size: assert property (@(posedge clk) disable iff (!xrst)
    (awvalid && awready) |-> (awsize == full_size(DATA_WIDTH)));

  a_ar_full_size: assert property (@(posedge clk) disable iff (!xrst)
    (arvalid && arready) |-> (arsize == full_size(DATA_WIDTH)));

  // master's wlast must agree with the burst length from the address phase
  a_wlast_match: assert property (@(posedge clk) disable iff (!xrst)
    w_step |-> (wlast == w_last));

  a_we_in_write: assert property (@(posedge clk) disable iff (!xrst)
    mem_we |-> (state == S_WRITE));

endmodule

`default_nettype wire

// File: src.f
ninjin_pkg.sv
ninjin_burst_addr.sv
ninjin_s_axi_gobou.sv
gobou_mem.sv
ninjin_gobou_top.sv
tb_ninjin_gobou.sv

// File: tb_ninjin_gobou.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ninjin_gobou;

  import ninjin_pkg::*;

  localparam int DW = 32;
  localparam int AW = 12;
  localparam int IW = 12;
  localparam logic [1:0] B_FIXED = 2'b00;
  localparam logic [1:0] B_INCR  = 2'b01;
  localparam logic [1:0] B_WRAP  = 2'b10;

  localparam int N_INCR  = 8;
  localparam int N_STALL = 4;
  // worst case beats of every test for write and read
  localparam int TOTAL_BEATS = 2 + 1024 + 2 * N_INCR * 16 + 2 * (4 + 4 + 8) + 8
                               + 2 * N_STALL * 16 + 16;
  localparam int TIMEOUT_CYCLES = TOTAL_BEATS * 20;

  logic            clk;
  logic            xrst;
  logic [IW-1:0]   awid;
  logic [AW-1:0]   awaddr;
  axi_len_t        awlen;
  axi_size_t       awsize;
  logic [1:0]      awburst;
  logic            awlock;
  logic [3:0]      awcache;
  logic [2:0]      awprot;
  logic [3:0]      awqos;
  logic [3:0]      awregion;
  logic            awvalid;
  logic            awready;
  logic [DW-1:0]   wdata;
  logic [DW/8-1:0] wstrb;
  logic            wlast;
  logic            wvalid;
  logic            wready;
  logic            bvalid;
  logic [IW-1:0]   bid;
  axi_resp_t       bresp;
  logic            bready;
  logic [IW-1:0]   arid;
  logic [AW-1:0]   araddr;
  axi_len_t        arlen;
  axi_size_t       arsize;
  logic [1:0]      arburst;
  logic            arlock;
  logic [3:0]      arcache;
  logic [2:0]      arprot;
  logic [3:0]      arqos;
  logic [3:0]      arregion;
  logic            arvalid;
  logic            arready;
  logic            rvalid;
  logic [IW-1:0]   rid;
  logic [DW-1:0]   rdata;
  axi_resp_t       rresp;
  logic            rlast;
  logic            rready;

  // expected values and bookkeeping
  logic [7:0]    shadow [4096];
  logic [31:0]   rng_state;
  string         test_name;
  logic          stall_on;
  logic          pair_mode;
  logic          busy;
  int            b_count;
  int            b_mark;
  logic [IW-1:0] exp_bid;
  logic [IW-1:0] exp_rid;
  logic [DW-1:0] exp_rdata;
  logic          exp_rlast;

  ninjin_gobou_top #(
    .DATA_WIDTH (DW),
    .ADDR_WIDTH (AW),
    .ID_WIDTH   (IW)
  ) DUT (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ========================================
  // reporting
  // ========================================

  task automatic abort_run();
    $display(">>> FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic report_mismatch(input string what, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("ERROR %s %s: expected %h actual %h", test_name, what, expected, actual);
    abort_run();
  endtask

  task automatic report_failure(input string msg);
    $display("%s: %s", test_name, msg);
    abort_run();
  endtask

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    report_failure("watchdog expired before the tests finished");
  end

  // ========================================
  // reference model
  // ========================================

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic draw(output logic [31:0] r);
    rng_state = xorshift32(rng_state);
    r = rng_state;
  endtask

  // address of the following 4 byte beat by the AXI burst rules
  function automatic logic [11:0] next_beat_addr(input logic [11:0] a, input logic [7:0] len,
                                                 input logic [1:0] burst);
    int total;
    int base;
    int nxt;
    total = (int'(len) + 1) * 4;
    nxt = int'(a) + 4;
    if (burst == B_FIXED) begin
      nxt = int'(a);
    end else if (burst == B_WRAP) begin
      base = (int'(a) / total) * total;
      if (nxt >= base + total) begin
        nxt = base;
      end
    end
    return 12'(nxt);
  endfunction

  function automatic logic [31:0] fill_word(input logic [11:0] a);
    return {a, 8'hc3, ~a};
  endfunction

  function automatic logic [31:0] shadow_word(input logic [11:0] a);
    return {shadow[a + 12'd3], shadow[a + 12'd2], shadow[a + 12'd1], shadow[a]};
  endfunction

  // ========================================
  // bus driver
  // ========================================

  task automatic write_burst(input logic [11:0] addr, input logic [7:0] len,
                             input logic [1:0] burst, input logic [IW-1:0] id,
                             input logic full_strb, input logic fill);
    logic [31:0] r;
    logic [31:0] d;
    logic [3:0]  s;
    logic [11:0] a;
    logic        done;
    exp_bid = id;
    awid    = id;
    awaddr  = addr;
    awlen   = len;
    awburst = burst;
    awvalid = 1'b1;
    do @(negedge clk); while (!awready);
    @(posedge clk);
    #1;
    awvalid = 1'b0;
    // bid must come from the accepted address, not the live input
    awid    = ~id;
    a = addr;
    for (int i = 0; i <= int'(len); i++) begin
      draw(r);
      if (stall_on && r[31]) begin
        wvalid = 1'b0;
        @(posedge clk);
        #1;
      end
      d = fill ? fill_word(a) : xorshift32(r);
      s = full_strb ? 4'hf : r[3:0];
      wdata  = d;
      wstrb  = s;
      wlast  = (i == int'(len));
      wvalid = 1'b1;
      do @(negedge clk); while (!wready);
      for (int b = 0; b < 4; b++) begin
        if (s[b]) begin
          shadow[a + 12'(b)] = d[b*8 +: 8];
        end
      end
      @(posedge clk);
      #1;
      a = next_beat_addr(a, len, burst);
    end
    wvalid = 1'b0;
    wlast  = 1'b0;
    done = 1'b0;
    while (!done) begin
      draw(r);
      bready = !stall_on || r[0];
      @(negedge clk);
      done = bvalid && bready;
      @(posedge clk);
      #1;
    end
    bready = 1'b0;
  endtask

  task automatic read_burst(input logic [11:0] addr, input logic [7:0] len,
                            input logic [1:0] burst, input logic [IW-1:0] id);
    logic [31:0] r;
    logic [11:0] a;
    logic        done;
    arid    = id;
    araddr  = addr;
    arlen   = len;
    arburst = burst;
    arvalid = 1'b1;
    do @(negedge clk); while (!arready);
    @(posedge clk);
    #1;
    arvalid = 1'b0;
    // rid must come from the accepted address, not the live input
    arid    = ~id;
    exp_rid = id;
    a = addr;
    for (int i = 0; i <= int'(len); i++) begin
      exp_rdata = shadow_word(a);
      exp_rlast = (i == int'(len));
      done = 1'b0;
      while (!done) begin
        draw(r);
        rready = !stall_on || r[0];
        @(negedge clk);
        done = rvalid && rready;
        @(posedge clk);
        #1;
      end
      a = next_beat_addr(a, len, burst);
    end
    rready = 1'b0;
  endtask

  // ========================================
  // checks
  // ========================================

  always @(posedge clk) begin
    if (!xrst) begin
      busy    <= 1'b0;
      b_count <= 0;
    end else begin
      if ((awvalid && awready) || (arvalid && arready)) begin
        busy <= 1'b1;
      end else if ((bvalid && bready) || (rvalid && rready && rlast)) begin
        busy <= 1'b0;
      end
      if (bvalid && bready) begin
        b_count <= b_count + 1;
      end
    end
  end

  a_reset_idle: assert property (@(posedge clk)
    !xrst |=> (!awready && !wready && !bvalid && !arready && !rvalid))
    else report_failure("a ready or valid output was high after reset");

  a_rdata: assert property (@(posedge clk) disable iff (!xrst)
    (rvalid && rready) |-> (rdata == exp_rdata))
    else report_mismatch("rdata", $sampled(exp_rdata), $sampled(rdata));

  a_rlast: assert property (@(posedge clk) disable iff (!xrst)
    (rvalid && rready) |-> (rlast == exp_rlast))
    else report_mismatch("rlast", 32'($sampled(exp_rlast)), 32'($sampled(rlast)));

  a_rid: assert property (@(posedge clk) disable iff (!xrst)
    (rvalid && rready) |-> ({rid, rresp} == {exp_rid, RESP_OKAY}))
    else report_mismatch("rid and rresp", 32'({$sampled(exp_rid), RESP_OKAY}),
                         32'({$sampled(rid), $sampled(rresp)}));

  a_bresp: assert property (@(posedge clk) disable iff (!xrst)
    (bvalid && bready) |-> ({bid, bresp} == {exp_bid, RESP_OKAY}))
    else report_mismatch("bid and bresp", 32'({$sampled(exp_bid), RESP_OKAY}),
                         32'({$sampled(bid), $sampled(bresp)}));

  a_b_hold: assert property (@(posedge clk) disable iff (!xrst)
    (bvalid && !bready) |=> (bvalid && $stable(bid) && $stable(bresp)))
    else report_failure("write response changed while bready was low");

  a_r_hold: assert property (@(posedge clk) disable iff (!xrst)
    (rvalid && !rready) |=> (rvalid && $stable(rdata) && $stable(rlast) && $stable(rid)))
    else report_failure("read data changed while rready was low");

  a_no_addr_busy: assert property (@(posedge clk) disable iff (!xrst)
    busy |-> (!awready && !arready))
    else report_failure("an address ready came during a transaction");

  a_read_after_write: assert property (@(posedge clk) disable iff (!xrst)
    (pair_mode && arvalid && arready) |-> (b_count != b_mark))
    else report_failure("read address taken before the write response");

  // ========================================
  // test sequence
  // ========================================

  initial begin
    logic [31:0] r;
    logic [11:0] a;
    logic [7:0]  len;
    rng_state = 32'd30;
    test_name = "reset";
    stall_on  = 1'b0;
    pair_mode = 1'b0;
    b_mark    = 0;
    exp_bid   = '0;
    exp_rid   = '0;
    exp_rdata = '0;
    exp_rlast = 1'b0;
    xrst      = 1'b0;
    {awid, awaddr, awlen, awburst, awvalid} = '0;
    {awlock, awcache, awprot, awqos, awregion} = '0;
    {arid, araddr, arlen, arburst, arvalid} = '0;
    {arlock, arcache, arprot, arqos, arregion} = '0;
    awsize = 3'd2;
    arsize = 3'd2;
    {wdata, wstrb, wlast, wvalid, bready, rready} = '0;
    repeat (2) @(posedge clk);
    #1;
    xrst = 1'b1;

    test_name = "single_beat";
    write_burst(12'h100, 8'd0, B_INCR, 12'h5a1, 1'b1, 1'b0);
    read_burst(12'h100, 8'd0, B_INCR, 12'h3c2);

    // whole memory gets known contents before partial strobes
    test_name = "fill";
    for (int w = 0; w < 64; w++) begin
      write_burst(12'(w * 64), 8'd15, B_INCR, 12'(w), 1'b1, 1'b1);
    end

    test_name = "incr";
    for (int n = 0; n < N_INCR; n++) begin
      draw(r);
      len = 8'(r % 16);
      a = 12'(((r >> 8) % 1008) * 4);
      write_burst(a, len, B_INCR, 12'(r >> 20), 1'b0, 1'b0);
      read_burst(a, len, B_INCR, 12'(r));
    end

    test_name = "wrap";
    draw(r);
    a = 12'((r % 64) * 64 + 8);
    write_burst(a, 8'd3, B_WRAP, 12'h0a4, 1'b0, 1'b0);
    read_burst(a, 8'd3, B_WRAP, 12'h0a5);
    read_burst(a & 12'hff0, 8'd3, B_INCR, 12'h0a6);
    draw(r);
    a = 12'((r % 64) * 64 + 20);
    write_burst(a, 8'd7, B_WRAP, 12'h0a8, 1'b0, 1'b0);
    read_burst(a, 8'd7, B_WRAP, 12'h0a9);

    test_name = "fixed";
    write_burst(12'h7f0, 8'd3, B_FIXED, 12'h0f1, 1'b1, 1'b0);
    read_burst(12'h7f0, 8'd3, B_FIXED, 12'h0f2);

    test_name = "stall";
    stall_on = 1'b1;
    for (int n = 0; n < N_STALL; n++) begin
      draw(r);
      len = 8'(r % 16);
      a = 12'(((r >> 8) % 1008) * 4);
      write_burst(a, len, B_INCR, 12'(r >> 20), 1'b0, 1'b0);
      read_burst(a, len, B_INCR, 12'(r));
    end
    stall_on = 1'b0;

    // both address channels valid in one idle cycle
    test_name = "write_wins";
    draw(r);
    a = 12'((r % 1000) * 4);
    b_mark = b_count;
    pair_mode = 1'b1;
    fork
      write_burst(a, 8'd7, B_INCR, 12'h6e1, 1'b0, 1'b0);
      read_burst(a, 8'd7, B_INCR, 12'h6e2);
    join
    pair_mode = 1'b0;

    $display(">>> PASS");
    $finish;
  end

endmodule

`default_nettype wire
